/* compile.f */
src/pkt_steer_pkg.sv
src/pkt_decode.sv
src/pkt_execute.sv
src/pkt_result.sv
src/pkt_steer_top.sv
tb/pkt_steer_sva.sv
tb/tb_pkt_steer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the packet steering testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        -f compile.f --top-module tb_pkt_steer \
        -Mdir obj_dir -o tb_pkt_steer; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_pkt_steer > "$log" 2>&1; then
    cat "$log"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$log"

if grep -q "Test failures found" "$log"; then
    exit 1
fi
if ! grep -q "All tests passed!" "$log"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* src/pkt_decode.sv */
`timescale 1ns/10ps

module pkt_decode (
    input  logic                                axil_if,
    input  logic                                arst_n,
    input  logic                                advance,
    input  logic                                in_valid,
    input  logic [pkt_steer_pkg::data_w-1:0]    in_data,
    input  logic [pkt_steer_pkg::port_w-1:0]    in_id,
    output logic                                dec_valid,
    output pkt_steer_pkg::act_e                 dec_act,
    output logic [pkt_steer_pkg::key_w-1:0]     dec_key,
    output logic [pkt_steer_pkg::port_w-1:0]    dec_id,
    output logic [pkt_steer_pkg::data_w-1:0]    dec_data
);

    logic [pkt_steer_pkg::op_w-1:0] opcode;
    pkt_steer_pkg::act_e            act_next;

    // Opcode in the top nibble, key just below it
    assign opcode = in_data[pkt_steer_pkg::data_w-1 -: pkt_steer_pkg::op_w];

    always_comb begin
        case (opcode)
            4'd0:    act_next = pkt_steer_pkg::act_forward;
            4'd1:    act_next = pkt_steer_pkg::act_drop;
            4'd2:    act_next = pkt_steer_pkg::act_loopback;
            4'd3:    act_next = pkt_steer_pkg::act_tag;
            // Unknown opcodes are discarded
            default: act_next = pkt_steer_pkg::act_drop;
        endcase
    end

    // =========================================================================
    // Stage register
    // =========================================================================
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
        end else if (advance) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge axil_if) begin
        if (advance) begin
            dec_act  <= act_next;
            dec_key  <= in_data[pkt_steer_pkg::data_w-pkt_steer_pkg::op_w-1 -:
                                pkt_steer_pkg::key_w];
            dec_id   <= in_id;
            dec_data <= in_data;
        end
    end

endmodule

/* src/pkt_execute.sv */
`timescale 1ns/10ps

module pkt_execute (
    input  logic                                    axil_if,
    input  logic                                    arst_n,
    input  logic                                    advance,
    input  logic                                    dec_valid,
    input  pkt_steer_pkg::act_e                     dec_act,
    input  logic [pkt_steer_pkg::key_w-1:0]         dec_key,
    input  logic [pkt_steer_pkg::port_w-1:0]        dec_id,
    input  logic [pkt_steer_pkg::data_w-1:0]        dec_data,
    input  logic                                    reg_wr,
    input  logic                                    reg_rd,
    input  logic [pkt_steer_pkg::reg_addr_w-1:0]    reg_addr,
    input  logic [pkt_steer_pkg::reg_data_w-1:0]    reg_wdata,
    output logic [pkt_steer_pkg::reg_data_w-1:0]    reg_rdata,
    output logic                                    exe_valid,
    output pkt_steer_pkg::act_e                     exe_act,
    output logic [pkt_steer_pkg::port_w-1:0]        exe_dest,
    output logic [pkt_steer_pkg::data_w-1:0]        exe_data
);

    logic [pkt_steer_pkg::port_w-1:0]       port_tbl [0:3];
    logic [pkt_steer_pkg::tag_w-1:0]        tag_val;
    logic [pkt_steer_pkg::reg_data_w-1:0]   drop_cnt;
    logic [pkt_steer_pkg::reg_data_w-1:0]   emit_cnt;
    logic [pkt_steer_pkg::reg_data_w-1:0]   rd_value;
    logic [pkt_steer_pkg::port_w-1:0]       dest_next;
    logic [pkt_steer_pkg::data_w-1:0]       data_next;
    logic                                   is_drop;

    // =========================================================================
    // Management registers
    // =========================================================================
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                port_tbl[i] <= '0;
            end
            tag_val <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                pkt_steer_pkg::reg_port_0, pkt_steer_pkg::reg_port_1,
                pkt_steer_pkg::reg_port_2, pkt_steer_pkg::reg_port_3:
                    port_tbl[reg_addr[1:0]] <= reg_wdata[pkt_steer_pkg::port_w-1:0];
                pkt_steer_pkg::reg_tag:
                    tag_val <= reg_wdata[pkt_steer_pkg::tag_w-1:0];
                default: ;
            endcase
        end
    end

    // Read mux with zero extension
    always_comb begin
        rd_value = '0;
        case (reg_addr)
            pkt_steer_pkg::reg_port_0, pkt_steer_pkg::reg_port_1,
            pkt_steer_pkg::reg_port_2, pkt_steer_pkg::reg_port_3:
                rd_value[pkt_steer_pkg::port_w-1:0] = port_tbl[reg_addr[1:0]];
            pkt_steer_pkg::reg_tag:      rd_value[pkt_steer_pkg::tag_w-1:0] = tag_val;
            pkt_steer_pkg::reg_drop_cnt: rd_value = drop_cnt;
            pkt_steer_pkg::reg_emit_cnt: rd_value = emit_cnt;
            default: ;
        endcase
    end

    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_value;
        end
    end

    // =========================================================================
    // Match-action
    // =========================================================================
    assign is_drop = (dec_act == pkt_steer_pkg::act_drop);

    always_comb begin
        dest_next = port_tbl[dec_key];
        data_next = dec_data;
        if (dec_act == pkt_steer_pkg::act_loopback) begin
            dest_next = dec_id;
        end
        if (dec_act == pkt_steer_pkg::act_tag) begin
            data_next[pkt_steer_pkg::tag_w-1:0] = tag_val;
        end
    end

    // Drops free their slot here and are counted as they pass
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            exe_valid <= 1'b0;
            drop_cnt  <= '0;
            emit_cnt  <= '0;
        end else if (advance) begin
            exe_valid <= dec_valid && !is_drop;
            if (dec_valid && is_drop) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
            if (dec_valid && !is_drop) begin
                emit_cnt <= emit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge axil_if) begin
        if (advance) begin
            exe_act  <= dec_act;
            exe_dest <= dest_next;
            exe_data <= data_next;
        end
    end

endmodule

/* src/pkt_result.sv */
`timescale 1ns/10ps

module pkt_result (
    input  logic                                axil_if,
    input  logic                                arst_n,
    input  logic                                exe_valid,
    input  pkt_steer_pkg::act_e                 exe_act,
    input  logic [pkt_steer_pkg::port_w-1:0]    exe_dest,
    input  logic [pkt_steer_pkg::data_w-1:0]    exe_data,
    input  logic                                out_ready,
    output logic                                advance,
    output logic                                out_valid,
    output logic [pkt_steer_pkg::data_w-1:0]    out_data,
    output logic [pkt_steer_pkg::port_w-1:0]    out_dest
);

    // Set when the word in the output register was tagged
    logic out_tagged;

    // =========================================================================
    // Stall rule
    // =========================================================================
    // The pipeline moves when the output slot is free or being taken.
    // A stalled output freezes every stage at once
    assign advance = !out_valid || out_ready;

    // =========================================================================
    // Output register
    // =========================================================================
    always_ff @(posedge axil_if or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= exe_valid;
        end
    end

    always_ff @(posedge axil_if) begin
        if (advance) begin
            out_data   <= exe_data;
            out_dest   <= exe_dest;
            out_tagged <= exe_valid && (exe_act == pkt_steer_pkg::act_tag);
        end
    end

endmodule

/* src/pkt_steer_pkg.sv */
package pkt_steer_pkg;

    // =========================================================================
    // Widths
    // =========================================================================
    localparam int data_w     = 64;
    localparam int port_w     = 2;
    localparam int tag_w      = 16;
    localparam int op_w       = 4;
    localparam int key_w      = 2;
    localparam int reg_addr_w = 3;
    localparam int reg_data_w = 32;

    // =========================================================================
    // Management register map
    // =========================================================================
    localparam logic [reg_addr_w-1:0] reg_port_0   = 3'd0;
    localparam logic [reg_addr_w-1:0] reg_port_1   = 3'd1;
    localparam logic [reg_addr_w-1:0] reg_port_2   = 3'd2;
    localparam logic [reg_addr_w-1:0] reg_port_3   = 3'd3;
    localparam logic [reg_addr_w-1:0] reg_tag      = 3'd4;
    // Counters are read only
    localparam logic [reg_addr_w-1:0] reg_drop_cnt = 3'd5;
    localparam logic [reg_addr_w-1:0] reg_emit_cnt = 3'd6;

    // =========================================================================
    // Packet actions
    // =========================================================================
    // Values match the opcode in the top nibble
    typedef enum logic [1:0] {
        act_forward  = 2'd0,
        act_drop     = 2'd1,
        act_loopback = 2'd2,
        act_tag      = 2'd3
    } act_e;

endpackage

/* src/pkt_steer_top.sv */
`timescale 1ns/10ps

module pkt_steer_top (
    input  logic                                    axil_if,
    input  logic                                    arst_n,
    // Packet input
    input  logic                                    in_valid,
    input  logic [pkt_steer_pkg::data_w-1:0]        in_data,
    input  logic [pkt_steer_pkg::port_w-1:0]        in_id,
    output logic                                    in_ready,
    // Packet output
    output logic                                    out_valid,
    output logic [pkt_steer_pkg::data_w-1:0]        out_data,
    output logic [pkt_steer_pkg::port_w-1:0]        out_dest,
    input  logic                                    out_ready,
    // Management
    input  logic                                    reg_wr,
    input  logic                                    reg_rd,
    input  logic [pkt_steer_pkg::reg_addr_w-1:0]    reg_addr,
    input  logic [pkt_steer_pkg::reg_data_w-1:0]    reg_wdata,
    output logic [pkt_steer_pkg::reg_data_w-1:0]    reg_rdata
);

    logic                               advance;

    logic                               dec_valid;
    pkt_steer_pkg::act_e                dec_act;
    logic [pkt_steer_pkg::key_w-1:0]    dec_key;
    logic [pkt_steer_pkg::port_w-1:0]   dec_id;
    logic [pkt_steer_pkg::data_w-1:0]   dec_data;

    logic                               exe_valid;
    pkt_steer_pkg::act_e                exe_act;
    logic [pkt_steer_pkg::port_w-1:0]   exe_dest;
    logic [pkt_steer_pkg::data_w-1:0]   exe_data;

    // Input accepted whenever the pipeline moves
    assign in_ready = advance;

    // =========================================================================
    // Pipeline stages
    // =========================================================================
    pkt_decode pkt_decode_inst (
        .axil_if   ( axil_if ),
        .arst_n    ( arst_n ),
        .advance   ( advance ),
        .in_valid  ( in_valid ),
        .in_data   ( in_data ),
        .in_id     ( in_id ),
        .dec_valid ( dec_valid ),
        .dec_act   ( dec_act ),
        .dec_key   ( dec_key ),
        .dec_id    ( dec_id ),
        .dec_data  ( dec_data )
    );

    pkt_execute pkt_execute_inst (
        .axil_if   ( axil_if ),
        .arst_n    ( arst_n ),
        .advance   ( advance ),
        .dec_valid ( dec_valid ),
        .dec_act   ( dec_act ),
        .dec_key   ( dec_key ),
        .dec_id    ( dec_id ),
        .dec_data  ( dec_data ),
        .reg_wr    ( reg_wr ),
        .reg_rd    ( reg_rd ),
        .reg_addr  ( reg_addr ),
        .reg_wdata ( reg_wdata ),
        .reg_rdata ( reg_rdata ),
        .exe_valid ( exe_valid ),
        .exe_act   ( exe_act ),
        .exe_dest  ( exe_dest ),
        .exe_data  ( exe_data )
    );

    pkt_result pkt_result_inst (
        .axil_if   ( axil_if ),
        .arst_n    ( arst_n ),
        .exe_valid ( exe_valid ),
        .exe_act   ( exe_act ),
        .exe_dest  ( exe_dest ),
        .exe_data  ( exe_data ),
        .out_ready ( out_ready ),
        .advance   ( advance ),
        .out_valid ( out_valid ),
        .out_data  ( out_data ),
        .out_dest  ( out_dest )
    );

endmodule

/* tb/pkt_steer_sva.sv */
`timescale 1ns/10ps

module pkt_steer_sva (
    input  logic                                axil_if,
    input  logic                                arst_n,
    input  logic                                out_valid,
    input  logic                                out_ready,
    input  logic [pkt_steer_pkg::data_w-1:0]    out_data,
    input  logic [pkt_steer_pkg::port_w-1:0]    out_dest,
    input  logic                                out_tagged,
    input  logic [pkt_steer_pkg::tag_w-1:0]     tag_val
);

    // A tagged word leaves with the current tag in its low bits
    tag_intact: assert property (
        @(posedge axil_if) disable iff (!arst_n)
        out_valid && out_tagged |-> out_data[pkt_steer_pkg::tag_w-1:0] == tag_val
    ) else $error("tagged output word does not carry the tag value");

    // A stalled output word holds until taken
    output_held: assert property (
        @(posedge axil_if) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_dest)
    ) else $error("output word or destination changed while stalled");

    quiet_in_reset: assert property (
        @(posedge axil_if) !arst_n |-> !out_valid
    ) else $error("out_valid high while reset is asserted");

endmodule

bind pkt_steer_top pkt_steer_sva pkt_steer_sva_inst (
    .axil_if    ( axil_if ),
    .arst_n     ( arst_n ),
    .out_valid  ( out_valid ),
    .out_ready  ( out_ready ),
    .out_data   ( out_data ),
    .out_dest   ( out_dest ),
    .out_tagged ( pkt_result_inst.out_tagged ),
    .tag_val    ( pkt_execute_inst.tag_val )
);

/* tb/tb_pkt_steer.sv */
`timescale 1ns/10ps

module tb_pkt_steer;

    localparam int n_fwd = 200;
    localparam int n_drop = 120;
    localparam int n_tag = 60;
    localparam int n_bp = 300;
    localparam int cycle_limit = 40 * (n_fwd + n_drop + n_tag + n_bp) + 2000;

    logic                                   axil_if;
    logic                                   arst_n;
    logic                                   in_valid;
    logic [pkt_steer_pkg::data_w-1:0]       in_data;
    logic [pkt_steer_pkg::port_w-1:0]       in_id;
    logic                                   in_ready;
    logic                                   out_valid;
    logic [pkt_steer_pkg::data_w-1:0]       out_data;
    logic [pkt_steer_pkg::port_w-1:0]       out_dest;
    logic                                   out_ready;
    logic                                   reg_wr;
    logic                                   reg_rd;
    logic [pkt_steer_pkg::reg_addr_w-1:0]   reg_addr;
    logic [pkt_steer_pkg::reg_data_w-1:0]   reg_wdata;
    logic [pkt_steer_pkg::reg_data_w-1:0]   reg_rdata;

    // Reference model state
    // Expected words are {data, dest}
    logic [65:0]    exp_q [$];
    logic [1:0]     m_tbl [0:3];
    logic [15:0]    m_tag;
    logic [31:0]    m_drop;
    logic [31:0]    m_emit;

    logic [31:0]    lfsr;
    logic           bp_on;
    string          test_name;
    int             err_cnt;
    int             check_cnt;
    int             test_cnt;
    int             errs_start;
    int             cycle_cnt;

    pkt_steer_top pkt_steer_top_inst (.*);

    initial begin
        axil_if = 1'b0;
        forever #10 axil_if = ~axil_if;
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            err_cnt++;
            $display("error %s: expected 0x%h, actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errs_start = err_cnt;
    endtask

    task automatic finish_test();
        test_cnt++;
        if (err_cnt == errs_start) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: FAILED with %0d errors", test_name, err_cnt - errs_start);
        end
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] val);
        @(negedge axil_if);
        reg_wr = 1'b1;
        reg_addr = addr;
        reg_wdata = val;
        @(negedge axil_if);
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [31:0] val);
        @(negedge axil_if);
        reg_rd = 1'b1;
        reg_addr = addr;
        @(negedge axil_if);
        reg_rd = 1'b0;
        val = reg_rdata;
    endtask

    // Action rules applied to every accepted packet
    task automatic model_accept(input logic [63:0] d, input logic [1:0] id);
        logic [3:0] op;
        logic [1:0] key;
        op = d[63:60];
        key = d[59:58];
        if (op == 4'd0) begin
            exp_q.push_back({d, m_tbl[key]});
        end else if (op == 4'd2) begin
            exp_q.push_back({d, id});
        end else if (op == 4'd3) begin
            exp_q.push_back({d[63:16], m_tag, m_tbl[key]});
        end
        if (op == 4'd0 || op == 4'd2 || op == 4'd3) begin
            m_emit++;
        end else begin
            m_drop++;
        end
    endtask

    // Mode 0 sends forward and loopback
    // Mode 1 sends any opcode
    // Mode 2 sends tagged packets only
    task automatic send_burst(input int n, input int mode);
        logic [63:0] r;
        logic [63:0] d;
        logic [63:0] id;
        logic [3:0]  op;
        logic        have_pkt;
        int          sent;
        sent = 0;
        have_pkt = 1'b0;
        while (sent < n) begin
            @(negedge axil_if);
            if (bp_on) begin
                take_bits(2, r);
                out_ready = (r[1:0] != 2'd0);
            end
            if (!have_pkt) begin
                case (mode)
                    0: begin
                        take_bits(1, r);
                        op = r[0] ? 4'd2 : 4'd0;
                    end
                    1: begin
                        take_bits(4, r);
                        op = r[3:0];
                    end
                    default: op = 4'd3;
                endcase
                take_bits(60, d);
                take_bits(2, id);
                in_data = {op, d[59:0]};
                in_id = id[1:0];
                in_valid = 1'b1;
                have_pkt = 1'b1;
            end
            @(posedge axil_if);
            if (in_ready) begin
                model_accept(in_data, in_id);
                sent++;
                have_pkt = 1'b0;
            end
        end
        @(negedge axil_if);
        in_valid = 1'b0;
        out_ready = 1'b1;
    endtask

    // Output empties and then drops finish leaving execute
    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge axil_if);
        end
        repeat (4) @(negedge axil_if);
    endtask

    // ========================================================================
    // Output monitor
    // ========================================================================
    always @(posedge axil_if) begin : out_monitor
        logic [65:0] exp;
        if (arst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("%s: output word appeared with no packet expected", test_name);
            end else begin
                exp = exp_q.pop_front();
                check_value({test_name, " data"}, exp[65:2], out_data);
                check_value({test_name, " dest"}, 64'(exp[1:0]), 64'(out_dest));
            end
        end
    end

    initial begin
        while (cycle_cnt < cycle_limit) begin
            @(posedge axil_if);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Test failures found");
        $finish;
    end

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin : main_seq
        logic [31:0] rd;
        logic [63:0] r;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_id = '0;
        out_ready = 1'b1;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        lfsr = 32'd70243;
        bp_on = 1'b0;
        m_drop = '0;
        m_emit = '0;
        repeat (16) @(negedge axil_if);
        arst_n = 1'b1;

        start_test("register_access");
        read_reg(pkt_steer_pkg::reg_drop_cnt, rd);
        check_value("register_access drop count", 64'd0, 64'(rd));
        read_reg(pkt_steer_pkg::reg_emit_cnt, rd);
        check_value("register_access emit count", 64'd0, 64'(rd));
        // Unused address
        read_reg(3'd7, rd);
        check_value("register_access addr 7", 64'd0, 64'(rd));
        for (int i = 0; i < 4; i++) begin
            take_bits(2, r);
            m_tbl[i] = r[1:0];
            write_reg(pkt_steer_pkg::reg_port_0 + 3'(i), {30'd0, r[1:0]});
        end
        take_bits(16, r);
        m_tag = r[15:0];
        write_reg(pkt_steer_pkg::reg_tag, {16'd0, m_tag});
        write_reg(pkt_steer_pkg::reg_drop_cnt, 32'hffff_ffff);
        read_reg(pkt_steer_pkg::reg_drop_cnt, rd);
        check_value("register_access read-only write", 64'd0, 64'(rd));
        for (int i = 0; i < 4; i++) begin
            read_reg(pkt_steer_pkg::reg_port_0 + 3'(i), rd);
            check_value("register_access table", 64'(m_tbl[i]), 64'(rd));
        end
        read_reg(pkt_steer_pkg::reg_tag, rd);
        check_value("register_access tag", 64'(m_tag), 64'(rd));
        finish_test();

        start_test("forward_loopback");
        send_burst(n_fwd, 0);
        wait_drain();
        finish_test();

        start_test("drop_unknown");
        send_burst(n_drop, 1);
        wait_drain();
        read_reg(pkt_steer_pkg::reg_drop_cnt, rd);
        check_value("drop_unknown drop count", 64'(m_drop), 64'(rd));
        finish_test();

        start_test("tagging");
        send_burst(n_tag, 2);
        wait_drain();
        read_reg(pkt_steer_pkg::reg_emit_cnt, rd);
        check_value("tagging emit count", 64'(m_emit), 64'(rd));
        finish_test();

        start_test("back_pressure");
        bp_on = 1'b1;
        send_burst(n_bp, 1);
        bp_on = 1'b0;
        wait_drain();
        read_reg(pkt_steer_pkg::reg_drop_cnt, rd);
        check_value("back_pressure drop count", 64'(m_drop), 64'(rd));
        read_reg(pkt_steer_pkg::reg_emit_cnt, rd);
        check_value("back_pressure emit count", 64'(m_emit), 64'(rd));
        finish_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
